//--- rtl/fp32_pkg.sv
package fp32_pkg;

   // binary32 field widths
   localparam int exp_w = 8;
   localparam int man_w = 23;

   localparam logic [exp_w-1:0] exp_max = 8'd255;
   localparam int exp_bias = 127;

   typedef struct packed {
      logic             sign;
      logic [exp_w-1:0] exp;
      logic [man_w-1:0] man;
   } fp32_t;

   // operand class, decided once at the seed stage
   typedef enum logic [1:0] {
      class_normal,
      class_zero,
      class_inf,
      class_nan
   } fp_class_e;

endpackage

//--- rtl/recip_pkg.sv
package recip_pkg;

   // estimate is 2.24 fixed point
   localparam int est_w = 26;
   localparam int est_frac_w = 24;

   // significand with the hidden one
   localparam int sig_w = fp32_pkg::man_w + 1;

   typedef logic [est_w-1:0] est_t;

   // 1 / midpoint of the mantissa interval selected by idx
   // midpoint is 1 + (2*idx + 1) / 2^(idx_w + 1)
   function automatic est_t seed_value(input int unsigned idx, input int unsigned idx_w);
      logic [63:0] num;
      logic [63:0] den;
      logic [63:0] quo;
      num = 64'd1 << (idx_w + 1 + est_frac_w);
      den = (64'd1 << (idx_w + 1)) + 64'(2 * idx + 1);
      // round to nearest
      quo = (num + (den >> 1)) / den;
      return est_t'(quo);
   endfunction

endpackage

//--- rtl/recip_stage_if.sv
`default_nettype none

interface recip_stage_if;

   logic                              valid;
   fp32_pkg::fp_class_e               cls;
   logic                              sign;
   logic [fp32_pkg::exp_w-1:0]        exp;
   // 1.23 fixed point
   logic [recip_pkg::sig_w-1:0]       sig;
   recip_pkg::est_t                   est;

   modport src (
      output valid,
      output cls,
      output sign,
      output exp,
      output sig,
      output est
   );

   modport dst (
      input valid,
      input cls,
      input sign,
      input exp,
      input sig,
      input est
   );

endinterface

`default_nettype wire

//--- rtl/recip_seed.sv
`default_nettype none

module recip_seed #(
   parameter int seed_bits = 8
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_valid,
   input  fp32_pkg::fp32_t in_x,
   recip_stage_if.src      stage
);

   localparam int table_n = 2 ** seed_bits;

   fp32_pkg::fp_class_e  cls;
   logic [seed_bits-1:0] idx;
   recip_pkg::est_t      seed_rom [table_n];

   // seed table, constant at elaboration
   for (genvar i = 0; i < table_n; i++) begin : g_rom
      assign seed_rom[i] = recip_pkg::seed_value(i, seed_bits);
   end

   assign idx = in_x.man[fp32_pkg::man_w-1 -: seed_bits];

   // zero exponent counts as zero, no subnormal support
   always_comb begin
      if (in_x.exp == fp32_pkg::exp_max) begin
         cls = (in_x.man != '0) ? fp32_pkg::class_nan : fp32_pkg::class_inf;
      end else if (in_x.exp == '0) begin
         cls = fp32_pkg::class_zero;
      end else begin
         cls = fp32_pkg::class_normal;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage.valid <= 1'b0;
      end else begin
         stage.valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         stage.cls  <= cls;
         stage.sign <= in_x.sign;
         stage.exp  <= in_x.exp;
         stage.sig  <= {1'b1, in_x.man};
         stage.est  <= seed_rom[idx];
      end
   end

   // seed in [0.5, 1), so integer bits clear and the half bit set
   a_seed_range: assert property (@(posedge clk) disable iff (!rst_n)
      stage.valid |-> stage.est[recip_pkg::est_w-1 -: 3] == 3'b001);

endmodule

`default_nettype wire

//--- rtl/recip_newton_stage.sv
`default_nettype none

module recip_newton_stage (
   input  logic       clk,
   input  logic       rst_n,
   recip_stage_if.dst prev,
   recip_stage_if.src next
);

   localparam int prod_w = recip_pkg::sig_w + recip_pkg::est_w;
   localparam int full_w = prod_w + recip_pkg::est_w;
   // fraction bits of sig * est
   localparam int drop = recip_pkg::sig_w - 1 + recip_pkg::est_frac_w;
   localparam logic [prod_w-1:0] two = prod_w'(1) << (drop + 1);

   logic [prod_w-1:0] prod;
   logic [prod_w-1:0] corr;
   logic [full_w-1:0] full;
   recip_pkg::est_t   est_trunc;
   logic              rnd;
   logic              sticky;
   recip_pkg::est_t   est_next;

   // est * (2 - sig * est)
   assign prod = prev.sig * prev.est;
   assign corr = two - prod;
   assign full = prev.est * corr;

   // back to 2.24, ties to even
   assign est_trunc = full[drop +: recip_pkg::est_w];
   assign rnd       = full[drop-1];
   assign sticky    = |full[drop-2:0];
   assign est_next  = est_trunc + recip_pkg::est_t'(rnd & (sticky | est_trunc[0]));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         next.valid <= 1'b0;
      end else begin
         next.valid <= prev.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (prev.valid) begin
         next.cls  <= prev.cls;
         next.sign <= prev.sign;
         next.exp  <= prev.exp;
         next.sig  <= prev.sig;
         next.est  <= est_next;
      end
   end

   a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(next.valid));

endmodule

`default_nettype wire

//--- rtl/recip_pack.sv
`default_nettype none

module recip_pack (
   input  logic            clk,
   input  logic            rst_n,
   recip_stage_if.dst      stage,
   output logic            out_valid,
   output fp32_pkg::fp32_t out_y,
   output logic            out_nan
);

   localparam int man_w = fp32_pkg::man_w;
   localparam int ew = fp32_pkg::exp_w + 2;

   logic            is_pow2;
   logic [ew-1:0]   exp_base;
   logic [ew-1:0]   res_exp;
   logic            flush;
   logic            nan_c;
   fp32_pkg::fp32_t y_c;

   assign is_pow2 = (stage.sig[man_w-1:0] == '0);

   // 1/2^e is exact, anything else sits one binade lower
   assign exp_base = is_pow2 ? ew'(2 * fp32_pkg::exp_bias) : ew'(2 * fp32_pkg::exp_bias - 1);
   assign res_exp  = exp_base - ew'(stage.exp);

   // would be subnormal or less
   assign flush = res_exp[ew-1] | (res_exp == '0);

   always_comb begin
      y_c.sign = stage.sign;
      y_c.exp  = '0;
      y_c.man  = '0;
      nan_c    = 1'b0;
      case (stage.cls)
         fp32_pkg::class_nan: begin
            // quiet the payload
            y_c.exp = fp32_pkg::exp_max;
            y_c.man = {1'b1, stage.sig[man_w-2:0]};
            nan_c   = 1'b1;
         end
         fp32_pkg::class_inf: begin
            y_c.exp = '0;
         end
         fp32_pkg::class_zero: begin
            y_c.exp = fp32_pkg::exp_max;
         end
         default: begin
            if (!flush) begin
               y_c.exp = res_exp[fp32_pkg::exp_w-1:0];
               // 2.24 estimate in [0.5, 1) holds 24 significant bits, hidden one at bit 23
               y_c.man = is_pow2 ? '0 : stage.est[man_w-1:0];
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
         out_nan   <= 1'b0;
      end else begin
         out_valid <= stage.valid;
         out_nan   <= stage.valid & nan_c;
      end
   end

   always_ff @(posedge clk) begin
      if (stage.valid) begin
         out_y <= y_c;
      end
   end

   // a flagged result is always a valid quiet NaN
   a_nan_valid: assert property (@(posedge clk) disable iff (!rst_n)
      out_nan |-> out_valid && out_y.exp == fp32_pkg::exp_max && out_y.man[man_w-1]);

endmodule

`default_nettype wire

//--- rtl/recip_top.sv
`default_nettype none

module recip_top #(
   parameter int seed_bits    = 8,
   parameter int newton_steps = 2
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_valid,
   input  fp32_pkg::fp32_t in_x,
   output logic            out_valid,
   output fp32_pkg::fp32_t out_y,
   output logic            out_nan
);

   // one boundary after the seed and after each Newton step
   recip_stage_if stage_if [newton_steps+1] ();

   recip_seed #(
      .seed_bits(seed_bits)
   ) seed_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_x     (in_x),
      .stage    (stage_if[0])
   );

   for (genvar i = 0; i < newton_steps; i++) begin : g_newton
      recip_newton_stage newton_i (
         .clk   (clk),
         .rst_n (rst_n),
         .prev  (stage_if[i]),
         .next  (stage_if[i+1])
      );
   end

   recip_pack pack_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .stage     (stage_if[newton_steps]),
      .out_valid (out_valid),
      .out_y     (out_y),
      .out_nan   (out_nan)
   );

endmodule

`default_nettype wire

//--- bench/tb_recip.sv
module tb_recip;

   localparam int period       = 8;
   localparam int reset_cycles = 5;
   // default newton_steps + 2
   localparam int latency      = 4;
   localparam int n_random     = 2000;
   localparam int n_pow2       = 200;
   localparam int n_special    = 20;
   localparam int n_flush      = 30;
   localparam int n_cancel     = 3;
   localparam int n_burst      = 32;
   localparam int total_ops    = n_random + n_pow2 + n_special + n_flush + n_cancel + n_burst;
   localparam int num_tests    = 5;
   localparam int watchdog_time = (total_ops + 20 * num_tests) * period
                                + 2 * (reset_cycles + latency) * period;

   logic            clk;
   logic            rst_n;
   logic            in_valid;
   fp32_pkg::fp32_t in_x;
   logic            out_valid;
   fp32_pkg::fp32_t out_y;
   logic            out_nan;

   fp32_pkg::fp32_t want_q [$];
   logic            nan_q [$];
   bit              exact_q [$];
   int              sent_q [$];

   logic [31:0] rng;
   int          cyc;
   int          checks;
   int          errors;
   int          checks_at_start;
   int          errors_at_start;
   bit          lat_check;

   recip_top recip_top_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_x      (in_x),
      .out_valid (out_valid),
      .out_y     (out_y),
      .out_nan   (out_nan)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic logic [31:0] next_rand();
      logic [31:0] s;
      s = rng;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      rng = s;
      return s;
   endfunction

   // double precision 1/x rounded back to single and flushed below the normal range
   function automatic fp32_pkg::fp32_t real_recip(input fp32_pkg::fp32_t x);
      logic [10:0]     de;
      logic [63:0]     rb;
      logic [31:0]     mag;
      int              e;
      fp32_pkg::fp32_t y;
      de = 11'(x.exp) + 11'd896;
      rb = $realtobits(1.0 / $bitstoreal({x.sign, de, x.man, 29'd0}));
      e = int'(rb[62:52]) - 1023 + 127;
      y.sign = rb[63];
      y.exp = '0;
      y.man = '0;
      if (e > 0) begin
         mag = {1'b0, 8'(e), rb[51:29]};
         if (rb[28] && (rb[27:0] != '0 || rb[29])) begin
            mag = mag + 32'd1;
         end
         y.exp = mag[30:23];
         y.man = mag[22:0];
      end
      return y;
   endfunction

   task automatic expect_result(input fp32_pkg::fp32_t x);
      fp32_pkg::fp32_t y;
      logic            nan;
      bit              exact;
      nan = 1'b0;
      exact = 1'b1;
      y.sign = x.sign;
      y.exp = '0;
      y.man = '0;
      if (x.exp == 8'd255 && x.man != '0) begin
         y.exp = 8'd255;
         y.man = {1'b1, x.man[21:0]};
         nan = 1'b1;
      end else if (x.exp == 8'd0) begin
         y.exp = 8'd255;
      end else if (x.exp != 8'd255) begin
         y = real_recip(x);
         exact = (x.man == '0) || (y.exp == '0);
      end
      want_q.push_back(y);
      nan_q.push_back(nan);
      exact_q.push_back(exact);
      sent_q.push_back(cyc);
   endtask

   task automatic check_value(input string name, input fp32_pkg::fp32_t got,
                              input fp32_pkg::fp32_t want, input bit exact);
      int diff;
      bit ok;
      diff = int'({1'b0, got.exp, got.man}) - int'({1'b0, want.exp, want.man});
      if (exact || $isunknown(got)) begin
         ok = (got === want);
      end else begin
         ok = (got.sign == want.sign) && diff >= -1 && diff <= 1;
      end
      checks++;
      if (!ok) begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, want);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, want);
      end
   endtask

   task automatic check_latency(input int got, input int want);
      checks++;
      if (got != want) begin
         errors++;
         $display("Mismatch at %0t: latency got %0d expected %0d", $time, got, want);
      end
   endtask

   always @(negedge clk) begin : monitor
      fp32_pkg::fp32_t want;
      logic            nan;
      bit              exact;
      int              sent;
      if (rst_n && out_valid === 1'b1) begin
         if (want_q.size() == 0) begin
            errors++;
            $display("out_valid high at %0t with no result outstanding", $time);
         end else begin
            want = want_q.pop_front();
            nan = nan_q.pop_front();
            exact = exact_q.pop_front();
            sent = sent_q.pop_front();
            check_value("out_y", out_y, want, exact);
            check_flag("out_nan", out_nan, nan);
            if (lat_check) begin
               check_latency(cyc - sent, latency);
            end
         end
      end
   end

   task automatic drive_operand(input fp32_pkg::fp32_t x);
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      in_x = x;
      expect_result(x);
   endtask

   // operand that a reset cancels, so no result is expected
   task automatic drive_cancelled(input fp32_pkg::fp32_t x);
      @(posedge clk);
      #1;
      in_valid = 1'b1;
      in_x = x;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   // out_valid must stay low through reset and the pipeline fill
   task automatic apply_reset();
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      in_valid = 1'b0;
      repeat (reset_cycles) begin
         @(negedge clk);
         check_flag("out_valid", out_valid, 1'b0);
      end
      @(posedge clk);
      #1;
      rst_n = 1'b1;
      repeat (latency) begin
         @(negedge clk);
         check_flag("out_valid", out_valid, 1'b0);
      end
   endtask

   task automatic begin_test();
      checks_at_start = checks;
      errors_at_start = errors;
   endtask

   task automatic end_test(input int num, input string name);
      while (want_q.size() != 0) begin
         @(posedge clk);
      end
      $display("test %0d %s: %0d checks, %0d errors", num, name,
               checks - checks_at_start, errors - errors_at_start);
   endtask

   initial begin : watchdog
      #(watchdog_time);
      $display("watchdog expired at %0t with %0d results outstanding", $time, want_q.size());
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      fp32_pkg::fp32_t x;
      logic [31:0]     r;
      clk = 1'b0;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_x = '0;
      cyc = 0;
      checks = 0;
      errors = 0;
      lat_check = 1'b0;
      rng = 32'h9d8ba31d;
      apply_reset();

      begin_test();
      for (int i = 0; i < n_random; i++) begin
         r = next_rand();
         x.sign = r[31];
         x.man = r[22:0];
         x.exp = 8'(32'd1 + next_rand() % 32'd252);
         drive_operand(x);
      end
      drive_idle();
      end_test(1, "random normal operands");

      begin_test();
      for (int i = 0; i < n_pow2; i++) begin
         r = next_rand();
         x.sign = r[31];
         x.exp = 8'(32'd1 + r % 32'd253);
         x.man = '0;
         drive_operand(x);
      end
      drive_idle();
      end_test(2, "powers of two");

      begin_test();
      for (int i = 0; i < n_special; i++) begin
         r = next_rand();
         x.sign = i[0];
         x.exp = (i % 5 == 2 || i % 5 == 3) ? 8'd0 : 8'd255;
         case (i % 5)
            0: x.man = r[22:0] | 23'd1;
            3: x.man = r[22:0] | 23'd1;
            4: x.man = {1'b1, r[21:0]};
            default: x.man = '0;
         endcase
         drive_operand(x);
      end
      drive_idle();
      end_test(3, "special operands");

      begin_test();
      for (int i = 0; i < n_flush; i++) begin
         r = next_rand();
         x.sign = r[31];
         x.exp = (i % 3 == 0) ? 8'd253 : 8'd254;
         x.man = (i % 3 == 2) ? 23'd0 : (r[22:0] | 23'd1);
         drive_operand(x);
      end
      drive_idle();
      end_test(4, "flush to zero");

      begin_test();
      // these are still in the pipeline when reset hits
      for (int i = 0; i < n_cancel; i++) begin
         r = next_rand();
         x.sign = r[31];
         x.man = r[22:0];
         x.exp = 8'(32'd1 + next_rand() % 32'd252);
         drive_cancelled(x);
      end
      apply_reset();
      lat_check = 1'b1;
      for (int i = 0; i < n_burst; i++) begin
         r = next_rand();
         x.sign = r[31];
         x.man = r[22:0];
         x.exp = 8'(32'd1 + next_rand() % 32'd252);
         drive_operand(x);
      end
      drive_idle();
      end_test(5, "reset, back-to-back throughput and latency");
      lat_check = 1'b0;

      $display("total: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- sources.f
rtl/fp32_pkg.sv
rtl/recip_pkg.sv
rtl/recip_stage_if.sv
rtl/recip_seed.sv
rtl/recip_newton_stage.sv
rtl/recip_pack.sv
rtl/recip_top.sv
bench/tb_recip.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_recip
RTL_TOP   ?= recip_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)
	@! grep -q "TEST FAIL" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
